/* verilog/wasm_pkg.sv */
package wasm_pkg;

  localparam int CODE_AW = 8;
  localparam int WINDOW_BYTES = 9;
  localparam int STACK_DEPTH_W = 4;
  localparam int BLOCK_DEPTH_W = 3;

  // Block type bytes, high bit dropped
  localparam logic [6:0] BT_EMPTY = 7'h40;
  localparam logic [6:0] BT_I32 = 7'h7F;
  localparam logic [6:0] BT_I64 = 7'h7E;

  typedef enum logic [7:0] {
    op_unreachable = 8'h00, op_nop = 8'h01, op_block = 8'h02, op_loop = 8'h03,
    op_end = 8'h0B, op_br = 8'h0C, op_br_if = 8'h0D, op_drop = 8'h1A,
    op_i32_const = 8'h41, op_i64_const = 8'h42,
    op_i32_eqz = 8'h45, op_i32_eq = 8'h46, op_i32_ne = 8'h47,
    op_i64_eqz = 8'h50, op_i64_eq = 8'h51, op_i64_ne = 8'h52,
    op_i32_add = 8'h6A, op_i32_sub = 8'h6B, op_i64_add = 8'h7C, op_i64_sub = 8'h7D
  } opcode_t;

  typedef enum logic [3:0] {
    TRAP_NONE = 4'd0,
    TRAP_ENDED = 4'd1,
    TRAP_UNREACHABLE = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_STACK_EMPTY = 4'd4,
    TRAP_STACK_FULL = 4'd5,
    TRAP_TYPE_MISMATCH = 4'd6,
    TRAP_BLOCK_EMPTY = 4'd7
  } trap_t;

  typedef enum logic [1:0] {T_I32 = 2'd0, T_I64 = 2'd1} val_type_t;

  typedef struct packed {
    val_type_t tag;
    logic [63:0] val;
  } value_t;

  typedef enum logic {BK_BLOCK = 1'b0, BK_LOOP = 1'b1} block_kind_t;

  // Target is the loop start, or the address after a block's end
  typedef struct packed {
    block_kind_t kind;
    logic [6:0] rtype;
    logic [CODE_AW-1:0] target;
    logic [STACK_DEPTH_W:0] sidx;
  } block_entry_t;

  typedef enum logic [1:0] {SOP_NONE, SOP_PUSH, SOP_POP, SOP_CUT} stack_op_t;

  typedef struct packed {
    logic empty;
    logic full;
  } stack_status_t;

endpackage

/* verilog/stack_if.sv */
interface stack_if #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH_W = 4
);
  import wasm_pkg::*;

  stack_op_t op;
  payload_t push_data;
  logic [DEPTH_W:0] level;
  // Cut also pushes push_data on top of the new level
  logic cut_push;
  payload_t top;
  payload_t next;
  logic [DEPTH_W:0] index;
  stack_status_t status;

  modport ctrl (output op, push_data, level, cut_push, input top, next, index, status);
  modport store (input op, push_data, level, cut_push, output top, next, index, status);

endinterface

/* verilog/lifo_stack.sv */
module lifo_stack #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH_W = 4
) (
  input logic clk,
  input logic reset,
  stack_if.store port
);
  import wasm_pkg::*;

  payload_t mem [2 ** DEPTH_W];
  logic [DEPTH_W:0] idx;
  logic [DEPTH_W-1:0] wr_addr;
  logic [DEPTH_W-1:0] top_addr;
  logic [DEPTH_W-1:0] next_addr;
  logic wr_en;

  // A cut with push writes just above the new level
  assign wr_addr = (port.op == SOP_CUT) ? port.level[DEPTH_W-1:0] : idx[DEPTH_W-1:0];
  assign wr_en = (port.op == SOP_PUSH) || (port.op == SOP_CUT && port.cut_push);

  always_ff @(posedge clk) begin
    if (reset) begin
      idx <= '0;
    end else begin
      case (port.op)
        SOP_PUSH: idx <= idx + 1'b1;
        SOP_POP: idx <= idx - 1'b1;
        SOP_CUT: idx <= port.level + (DEPTH_W + 1)'(port.cut_push);
        default: idx <= idx;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= port.push_data;
    end
  end

  assign top_addr = idx[DEPTH_W-1:0] - DEPTH_W'(1);
  assign next_addr = idx[DEPTH_W-1:0] - DEPTH_W'(2);

  assign port.top = mem[top_addr];
  assign port.next = mem[next_addr];
  assign port.index = idx;
  // Full only when the index reaches the depth itself
  assign port.status = '{empty: (idx == '0), full: idx[DEPTH_W]};

endmodule

/* verilog/code_rom.sv */
module code_rom (
  input logic clk,
  input logic load_en,
  input logic [wasm_pkg::CODE_AW-1:0] load_addr,
  input logic [7:0] load_data,
  input logic rd_en,
  input logic [wasm_pkg::CODE_AW-1:0] rd_addr,
  output logic [wasm_pkg::WINDOW_BYTES-1:0][7:0] window
);
  import wasm_pkg::*;

  logic [7:0] mem [2 ** CODE_AW];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Byte 0 is the opcode; addresses wrap past the end
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int i = 0; i < WINDOW_BYTES; i++) begin
        window[i] <= mem[rd_addr + CODE_AW'(i)];
      end
    end
  end

endmodule

/* verilog/leb128_decoder.sv */
module leb128_decoder (
  input logic [7:0][7:0] bytes,
  output logic [63:0] imm,
  output logic [3:0] imm_len
);
  import wasm_pkg::*;

  logic done;

  // Low group first, stop after the first byte with bit 7 clear
  always_comb begin
    imm = '0;
    imm_len = '0;
    done = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (!done) begin
        imm[7*i +: 7] = bytes[i][6:0];
        imm_len = 4'(i + 1);
        done = !bytes[i][7];
      end
    end
  end

endmodule

/* verilog/exec_core.sv */
module exec_core (
  input logic clk,
  input logic reset,
  input logic start,
  input logic [wasm_pkg::WINDOW_BYTES-1:0][7:0] window,
  input logic [63:0] imm,
  input logic [3:0] imm_len,
  output logic rd_en,
  output logic [wasm_pkg::CODE_AW-1:0] rd_addr,
  stack_if.ctrl opnd,
  stack_if.ctrl blk,
  output wasm_pkg::trap_t trap
);
  import wasm_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_UNWIND, S_BRANCH} state_t;

  state_t state, nxt_state;
  logic [CODE_AW-1:0] pc, nxt_pc;
  logic [CODE_AW-1:0] imm_pc;
  logic [BLOCK_DEPTH_W-1:0] cnt, nxt_cnt;
  trap_t nxt_trap;
  opcode_t opcode;
  value_t top_v, next_v, res_v;
  block_entry_t blk_top, new_blk;
  val_type_t op_type, res_type;
  logic [63:0] alu;
  logic exit_tag_ok;
  logic do_exit;

  assign opcode = opcode_t'(window[0]);
  assign top_v = opnd.top;
  assign next_v = opnd.next;
  assign blk_top = blk.top;
  assign imm_pc = pc + CODE_AW'(imm_len) + CODE_AW'(1);
  assign rd_addr = pc;
  assign rd_en = (state == S_FETCH);

  assign new_blk = '{kind: (opcode == op_loop) ? BK_LOOP : BK_BLOCK,
                     rtype: window[1][6:0],
                     target: (opcode == op_loop) ? pc + CODE_AW'(2) : window[2],
                     sidx: opnd.index};

  assign exit_tag_ok = (blk_top.rtype == BT_I32 && top_v.tag == T_I32) ||
                       (blk_top.rtype == BT_I64 && top_v.tag == T_I64);

  // Operand and result tags per opcode
  always_comb begin
    op_type = T_I32;
    res_type = T_I32;
    case (opcode)
      op_i64_const, op_i64_add, op_i64_sub: begin
        op_type = T_I64;
        res_type = T_I64;
      end
      op_i64_eqz, op_i64_eq, op_i64_ne: op_type = T_I64;
      default: ;
    endcase
  end

  // Next is the left operand
  always_comb begin
    case (opcode)
      op_i32_const: alu = {32'b0, imm[31:0]};
      op_i64_const: alu = imm;
      op_i32_add: alu = {32'b0, next_v.val[31:0] + top_v.val[31:0]};
      op_i32_sub: alu = {32'b0, next_v.val[31:0] - top_v.val[31:0]};
      op_i64_add: alu = next_v.val + top_v.val;
      op_i64_sub: alu = next_v.val - top_v.val;
      op_i32_eq: alu = 64'(next_v.val[31:0] == top_v.val[31:0]);
      op_i32_ne: alu = 64'(next_v.val[31:0] != top_v.val[31:0]);
      op_i64_eq: alu = 64'(next_v.val == top_v.val);
      op_i64_ne: alu = 64'(next_v.val != top_v.val);
      op_i32_eqz: alu = 64'(top_v.val[31:0] == '0);
      op_i64_eqz: alu = 64'(top_v.val == '0);
      default: alu = '0;
    endcase
  end

  assign res_v = '{tag: res_type, val: alu};

  always_comb begin
    nxt_state = state;
    nxt_pc = pc;
    nxt_cnt = cnt;
    nxt_trap = trap;
    do_exit = 1'b0;
    opnd.op = SOP_NONE;
    opnd.push_data = res_v;
    opnd.level = '0;
    opnd.cut_push = 1'b0;
    blk.op = SOP_NONE;
    blk.push_data = new_blk;
    blk.level = '0;
    blk.cut_push = 1'b0;
    case (state)
      S_IDLE: begin
        if (start && trap == TRAP_NONE) begin
          nxt_state = S_FETCH;
          nxt_pc = '0;
        end
      end
      S_FETCH: nxt_state = S_WAIT;
      S_WAIT: nxt_state = S_EXEC;
      S_EXEC: begin
        nxt_state = S_FETCH;
        nxt_pc = pc + CODE_AW'(1);
        case (opcode)
          op_unreachable: nxt_trap = TRAP_UNREACHABLE;
          op_nop: ;
          op_block, op_loop: begin
            nxt_pc = (opcode == op_block) ? pc + CODE_AW'(3) : pc + CODE_AW'(2);
            if (blk.status.full) nxt_trap = TRAP_STACK_FULL;
            else blk.op = SOP_PUSH;
          end
          op_end: begin
            if (blk.status.empty) nxt_trap = TRAP_ENDED;
            else if (blk_top.kind == BK_LOOP) blk.op = SOP_POP;
            else do_exit = 1'b1;
          end
          op_br, op_br_if: begin
            if (opcode == op_br_if && opnd.status.empty) begin
              nxt_trap = TRAP_STACK_EMPTY;
            end else if (opcode == op_br_if && top_v.tag != T_I32) begin
              nxt_trap = TRAP_TYPE_MISMATCH;
            end else if (opcode == op_br_if && top_v.val[31:0] == '0) begin
              opnd.op = SOP_POP;
              nxt_pc = imm_pc;
            end else if (imm >= 64'(blk.index)) begin
              nxt_trap = TRAP_BLOCK_EMPTY;
            end else begin
              // Condition goes first, the block entries follow in UNWIND
              if (opcode == op_br_if) opnd.op = SOP_POP;
              nxt_cnt = imm[BLOCK_DEPTH_W-1:0];
              nxt_state = (imm == '0) ? S_BRANCH : S_UNWIND;
            end
          end
          op_drop: begin
            if (opnd.status.empty) nxt_trap = TRAP_STACK_EMPTY;
            else opnd.op = SOP_POP;
          end
          op_i32_const, op_i64_const: begin
            nxt_pc = imm_pc;
            if (opnd.status.full) nxt_trap = TRAP_STACK_FULL;
            else opnd.op = SOP_PUSH;
          end
          op_i32_eqz, op_i64_eqz: begin
            if (opnd.status.empty) begin
              nxt_trap = TRAP_STACK_EMPTY;
            end else if (top_v.tag != op_type) begin
              nxt_trap = TRAP_TYPE_MISMATCH;
            end else begin
              opnd.op = SOP_CUT;
              opnd.level = opnd.index - (STACK_DEPTH_W + 1)'(1);
              opnd.cut_push = 1'b1;
            end
          end
          op_i32_add, op_i32_sub, op_i32_eq, op_i32_ne,
          op_i64_add, op_i64_sub, op_i64_eq, op_i64_ne: begin
            if (opnd.index < (STACK_DEPTH_W + 1)'(2)) begin
              nxt_trap = TRAP_STACK_EMPTY;
            end else if (top_v.tag != op_type || next_v.tag != op_type) begin
              nxt_trap = TRAP_TYPE_MISMATCH;
            end else begin
              opnd.op = SOP_CUT;
              opnd.level = opnd.index - (STACK_DEPTH_W + 1)'(2);
              opnd.cut_push = 1'b1;
            end
          end
          default: nxt_trap = TRAP_UNKNOWN_OPCODE;
        endcase
      end
      S_UNWIND: begin
        blk.op = SOP_POP;
        nxt_cnt = cnt - 1'b1;
        if (cnt == BLOCK_DEPTH_W'(1)) nxt_state = S_BRANCH;
      end
      S_BRANCH: begin
        nxt_state = S_FETCH;
        // Loop keeps its entry and restarts the body
        if (blk_top.kind == BK_LOOP) begin
          opnd.op = SOP_CUT;
          opnd.level = blk_top.sidx;
          nxt_pc = blk_top.target;
        end else begin
          do_exit = 1'b1;
        end
      end
      default: nxt_state = S_IDLE;
    endcase

    // Leave the innermost block, carrying its result down to the entry level
    if (do_exit) begin
      blk.op = SOP_POP;
      opnd.op = SOP_CUT;
      opnd.level = blk_top.sidx;
      nxt_pc = blk_top.target;
      if (blk_top.rtype != BT_EMPTY) begin
        opnd.cut_push = 1'b1;
        opnd.push_data = top_v;
        if (opnd.index <= blk_top.sidx) nxt_trap = TRAP_STACK_EMPTY;
        else if (!exit_tag_ok) nxt_trap = TRAP_TYPE_MISMATCH;
      end
    end

    // A trap freezes both stacks and parks the core
    if (nxt_trap != TRAP_NONE) begin
      opnd.op = SOP_NONE;
      blk.op = SOP_NONE;
      nxt_state = S_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      pc <= '0;
      cnt <= '0;
      trap <= TRAP_NONE;
    end else begin
      state <= nxt_state;
      pc <= nxt_pc;
      cnt <= nxt_cnt;
      trap <= nxt_trap;
    end
  end

endmodule

/* verilog/wasm_cpu.sv */
module wasm_cpu (
  input logic clk,
  input logic reset,
  input logic load_en,
  input logic [wasm_pkg::CODE_AW-1:0] load_addr,
  input logic [7:0] load_data,
  input logic start,
  output logic [63:0] result,
  output wasm_pkg::val_type_t result_type,
  output logic result_empty,
  output wasm_pkg::trap_t trap
);
  import wasm_pkg::*;

  logic [WINDOW_BYTES-1:0][7:0] window;
  logic rd_en;
  logic [CODE_AW-1:0] rd_addr;
  logic [63:0] imm;
  logic [3:0] imm_len;
  value_t tos;

  stack_if #(.payload_t(value_t), .DEPTH_W(STACK_DEPTH_W)) opnd_if ();
  stack_if #(.payload_t(block_entry_t), .DEPTH_W(BLOCK_DEPTH_W)) blk_if ();

  code_rom rom (
    .clk(clk),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .rd_en(rd_en),
    .rd_addr(rd_addr),
    .window(window)
  );

  // Immediates start right after the opcode byte
  leb128_decoder leb (
    .bytes(window[8:1]),
    .imm(imm),
    .imm_len(imm_len)
  );

  lifo_stack #(.payload_t(value_t), .DEPTH_W(STACK_DEPTH_W)) operand_stack (
    .clk(clk),
    .reset(reset),
    .port(opnd_if.store)
  );

  lifo_stack #(.payload_t(block_entry_t), .DEPTH_W(BLOCK_DEPTH_W)) block_stack (
    .clk(clk),
    .reset(reset),
    .port(blk_if.store)
  );

  exec_core core (
    .clk(clk),
    .reset(reset),
    .start(start),
    .window(window),
    .imm(imm),
    .imm_len(imm_len),
    .rd_en(rd_en),
    .rd_addr(rd_addr),
    .opnd(opnd_if.ctrl),
    .blk(blk_if.ctrl),
    .trap(trap)
  );

  assign tos = opnd_if.top;
  assign result = tos.val;
  assign result_type = tos.tag;
  assign result_empty = opnd_if.status.empty;

endmodule

/* tests/clock_gen.sv */
module clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Power-on reset over the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* tests/wasm_cpu_sva.sv */
module wasm_cpu_sva (
  input logic clk,
  input logic reset,
  input wasm_pkg::trap_t trap,
  input wasm_pkg::val_type_t result_type,
  input logic result_empty
);
  timeunit 1ns;
  timeprecision 100ps;
  import wasm_pkg::*;

  int fail_count = 0;

  // Reset is synchronous, so the trap is clear one cycle later
  trap_cleared: assert property (@(posedge clk) reset |=> trap == TRAP_NONE)
    else begin
      fail_count++;
      $error("trap not cleared after reset");
    end

  trap_held: assert property (@(posedge clk)
    (trap != TRAP_NONE && !reset) |=> trap == $past(trap))
    else begin
      fail_count++;
      $error("trap changed without a reset");
    end

  // Only i32 and i64 tags exist
  tag_defined: assert property (@(posedge clk) disable iff (reset)
    !result_empty |-> result_type inside {T_I32, T_I64})
    else begin
      fail_count++;
      $error("undefined result tag on a non-empty stack");
    end

endmodule

bind wasm_cpu wasm_cpu_sva checks_i (
  .clk(clk),
  .reset(reset),
  .trap(trap),
  .result_type(result_type),
  .result_empty(result_empty)
);

/* tests/wasm_cpu_tb.sv */
module wasm_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import wasm_pkg::*;

  localparam int NUM_TESTS = 20;
  localparam int TEST_CYCLES = 100;
  localparam int RUN_LIMIT = 64;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 8 * 2;
  localparam logic [63:0] MASK56 = 64'h00FF_FFFF_FFFF_FFFF;

  logic clk;
  logic por_reset;
  logic test_reset;
  logic load_en;
  logic [CODE_AW-1:0] load_addr;
  logic [7:0] load_data;
  logic start;
  logic [63:0] result;
  val_type_t result_type;
  logic result_empty;
  trap_t trap;
  logic [7:0] prog [$];
  integer seed = 32'h9ce4_7fbc;

  clock_gen #(.PERIOD_NS(8)) clk_i (.clk(clk), .reset(por_reset));

  wasm_cpu dut_i (
    .clk(clk),
    .reset(por_reset || test_reset),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .start(start),
    .result(result),
    .result_type(result_type),
    .result_empty(result_empty),
    .trap(trap)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    stop_with_failure($sformatf("mismatch %s: expected %h, got %h", name, exp, got));
  endtask

  function automatic void emit(input logic [7:0] b);
    prog.push_back(b);
  endfunction

  // Unsigned LEB128, low group first
  function automatic void emit_leb(input logic [63:0] v);
    logic [63:0] rest;
    rest = v;
    do begin
      emit({rest[63:7] != '0, rest[6:0]});
      rest = rest >> 7;
    end while (rest != '0);
  endfunction

  function automatic void emit_const(input logic [7:0] op, input logic [63:0] v);
    emit(op);
    emit_leb(v);
  endfunction

  task automatic apply_reset();
    prog.delete();
    @(posedge clk);
    test_reset <= 1'b1;
    repeat (2) @(posedge clk);
    test_reset <= 1'b0;
  endtask

  // Load, start, then wait for any trap
  task automatic run_program();
    int cycles;
    foreach (prog[i]) begin
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= CODE_AW'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (trap == TRAP_NONE && cycles < RUN_LIMIT);
    if (trap == TRAP_NONE) stop_with_failure("program did not reach a trap in time");
  endtask

  task automatic check_result(input trap_t exp_trap, input logic exp_empty,
                              input val_type_t exp_type, input logic [63:0] exp_val);
    assert (trap == exp_trap) else report_mismatch("trap", 64'(exp_trap), 64'(trap));
    assert (result_empty == exp_empty)
      else report_mismatch("result_empty", 64'(exp_empty), 64'(result_empty));
    if (!exp_empty) begin
      assert (result_type == exp_type)
        else report_mismatch("result_type", 64'(exp_type), 64'(result_type));
      assert (result == exp_val) else report_mismatch("result", exp_val, result);
    end
  endtask

  // Idle cycles and a second start must not disturb the trap
  task automatic hold_trap(input trap_t exp_trap);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (4) @(negedge clk);
    assert (trap == exp_trap) else report_mismatch("trap", 64'(exp_trap), 64'(trap));
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired before the tests finished");
  end

  always @(negedge clk) begin
    if (dut_i.checks_i.fail_count != 0) stop_with_failure("a bound assertion failed");
  end

  initial begin
    logic [31:0] a32;
    logic [31:0] b32;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp;
    logic [7:0] ops [4];
    trap_t faults [4];
    int patch_outer;
    int patch_inner;

    test_reset = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    start = 1'b0;
    ops = '{8'h6A, 8'h6B, 8'h46, 8'h47};
    faults = '{TRAP_UNREACHABLE, TRAP_UNKNOWN_OPCODE, TRAP_STACK_EMPTY, TRAP_BLOCK_EMPTY};

    // i32 binary operators, second round with equal operands
    for (int round = 0; round < 2; round++) begin
      foreach (ops[k]) begin
        a32 = $random(seed);
        b32 = (round == 0) ? $random(seed) : a32;
        case (ops[k])
          8'h6A: exp = {32'b0, a32 + b32};
          8'h6B: exp = {32'b0, a32 - b32};
          8'h46: exp = 64'(a32 == b32);
          default: exp = 64'(a32 != b32);
        endcase
        apply_reset();
        emit_const(8'h41, 64'(a32));
        emit_const(8'h41, 64'(b32));
        emit(ops[k]);
        emit(8'h0B);
        run_program();
        check_result(TRAP_ENDED, 1'b0, T_I32, exp);
      end
    end

    // i64 add and sub; constants stay within eight LEB bytes
    for (int k = 0; k < 2; k++) begin
      a = {$random(seed), $random(seed)} & MASK56;
      b = {$random(seed), $random(seed)} & MASK56;
      exp = (k == 0) ? a + b : a - b;
      apply_reset();
      emit_const(8'h42, a);
      emit_const(8'h42, b);
      emit((k == 0) ? 8'h7C : 8'h7D);
      emit(8'h0B);
      run_program();
      check_result(TRAP_ENDED, 1'b0, T_I64, exp);
    end

    for (int k = 0; k < 2; k++) begin
      a = (k == 0) ? 64'h0 : ({$random(seed), $random(seed)} & MASK56);
      apply_reset();
      emit_const(8'h42, a);
      emit(8'h50);
      emit(8'h0B);
      run_program();
      check_result(TRAP_ENDED, 1'b0, T_I32, 64'(a == 64'h0));
    end

    // i32 block left early by a taken br_if
    a32 = $random(seed);
    b32 = $random(seed);
    apply_reset();
    emit(8'h02);
    emit(8'h7F);
    patch_inner = prog.size();
    emit(8'h00);
    emit_const(8'h41, 64'(a32));
    emit_const(8'h41, 64'd1);
    emit(8'h0D);
    emit(8'h00);
    emit_const(8'h41, 64'(b32));
    emit(8'h0B);
    prog[patch_inner] = 8'(prog.size());
    emit(8'h0B);
    run_program();
    check_result(TRAP_ENDED, 1'b0, T_I32, {32'b0, a32});

    // br 1 out of two empty blocks discards the pushed value
    apply_reset();
    emit(8'h02);
    emit(8'h40);
    patch_outer = prog.size();
    emit(8'h00);
    emit(8'h02);
    emit(8'h40);
    patch_inner = prog.size();
    emit(8'h00);
    emit_const(8'h41, 64'(a32));
    emit(8'h0C);
    emit(8'h01);
    emit(8'h0B);
    prog[patch_inner] = 8'(prog.size());
    emit(8'h0B);
    prog[patch_outer] = 8'(prog.size());
    emit(8'h0B);
    run_program();
    check_result(TRAP_ENDED, 1'b1, T_I32, 64'h0);

    // Loop with a false br_if falls through
    apply_reset();
    emit(8'h03);
    emit(8'h40);
    emit_const(8'h41, 64'd0);
    emit(8'h0D);
    emit(8'h00);
    emit(8'h0B);
    emit_const(8'h41, 64'(b32));
    emit(8'h0B);
    run_program();
    check_result(TRAP_ENDED, 1'b0, T_I32, {32'b0, b32});

    // Mixed tags; the stack stays frozen with the i64 on top
    b = {$random(seed), $random(seed)} & MASK56;
    apply_reset();
    emit_const(8'h41, 64'(a32));
    emit_const(8'h42, b);
    emit(8'h6A);
    emit(8'h0B);
    run_program();
    check_result(TRAP_TYPE_MISMATCH, 1'b0, T_I64, b);

    for (int k = 0; k < 4; k++) begin
      apply_reset();
      case (k)
        0: emit(8'h00);
        1: emit(8'hFF);
        2: emit(8'h1A);
        default: begin
          emit(8'h0C);
          emit(8'h03);
        end
      endcase
      run_program();
      check_result(faults[k], 1'b1, T_I32, 64'h0);
      hold_trap(faults[k]);
    end

    if (dut_i.checks_i.fail_count != 0) begin
      stop_with_failure("a bound assertion failed during the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* verilog.f */
verilog/wasm_pkg.sv
verilog/stack_if.sv
verilog/lifo_stack.sv
verilog/code_rom.sv
verilog/leb128_decoder.sv
verilog/exec_core.sv
verilog/wasm_cpu.sv
tests/clock_gen.sv
tests/wasm_cpu_sva.sv
tests/wasm_cpu_tb.sv

/* Makefile */
SIM = obj_dir/Vwasm_cpu_tb

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

$(SIM): verilog.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module wasm_cpu_tb -o Vwasm_cpu_tb

clean:
	rm -rf obj_dir
